//--- flist.f
+incdir+verif
logic/backend_pkg.sv
logic/issue.sv
logic/reg_file.sv
logic/backend_pipeline.sv
logic/stall_clear_ctrl.sv
logic/backend.sv
verif/tb_backend.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_backend
FLIST     := flist.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/backend_model.svh
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

localparam int PROG_LEN = 200;

logic [31:0] rng_state = 32'd59;
inst_t       prog [PROG_LEN];
commit_t     exp_commits [$]; // program order
pc_t         exp_targets [$]; // one per taken branch

function automatic logic [31:0] xorshift_next();
	logic [31:0] x;
	x = rng_state;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	rng_state = x;
	return x;
endfunction

// registers 0..7 only, so dependences are frequent
function automatic void build_program();
	int pick;
	int tgt;
	for (int i = 0; i < PROG_LEN; i++) begin
		pick = int'(xorshift_next() % 16);
		prog[i].pc     = pc_t'(i);
		prog[i].rd     = reg_addr_t'(xorshift_next() % 8);
		prog[i].rs1    = reg_addr_t'(xorshift_next() % 8);
		prog[i].rs2    = reg_addr_t'(xorshift_next() % 8);
		prog[i].target = '0;
		if (pick < 11) begin
			prog[i].op = op_t'(pick % 6); // add .. slt
		end else if (pick < 14) begin
			prog[i].op = OP_MUL;
		end else begin
			prog[i].op = OP_BEQ;
			tgt = i + 2 + int'(xorshift_next() % 6); // forward only
			if (tgt > PROG_LEN) begin
				tgt = PROG_LEN;
			end
			prog[i].target = pc_t'(tgt);
			if (xorshift_next() % 2 == 0) begin
				prog[i].rs2 = prog[i].rs1;
			end
		end
	end
endfunction

// plain sequential execution, one instruction at a time
function automatic void run_reference();
	data_t   regs [32];
	data_t   a;
	data_t   b;
	data_t   res;
	commit_t c;
	int      pc;
	for (int r = 0; r < 32; r++) begin
		regs[r] = '0;
	end
	pc = 0;
	while (pc < PROG_LEN) begin
		a = regs[prog[pc].rs1];
		b = regs[prog[pc].rs2];
		case (prog[pc].op)
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_SLT:  res = data_t'($signed(a) < $signed(b));
			OP_MUL:  res = a * b; // low 32 bits
			default: res = '0;    // beq carries no value
		endcase
		c = '0;
		c.valid  = 1'b1;
		c.pc     = prog[pc].pc;
		c.rd     = (prog[pc].op == OP_BEQ) ? reg_addr_t'(0) : prog[pc].rd;
		c.result = res;
		exp_commits.push_back(c);
		if (c.rd != '0) begin
			regs[c.rd] = res;
		end
		if (prog[pc].op == OP_BEQ && a == b) begin
			exp_targets.push_back(prog[pc].target);
			pc = int'(prog[pc].target);
		end else begin
			pc++;
		end
	end
endfunction

`endif

//--- verif/tb_backend.sv
module tb_backend
	import backend_pkg::*;
();

	`include "backend_model.svh"

	localparam int MUL_CYCLES  = 3;
	localparam int PERIOD      = 20;
	localparam int DRIVE_DLY   = 2;
	localparam int RST_CYCLES  = 4;
	localparam int TAIL_CYCLES = 10; // catches stray commits after the last one
	localparam int WATCHDOG_T  =
		(PROG_LEN * (MUL_CYCLES + 4) + RST_CYCLES + TAIL_CYCLES) * PERIOD;

	logic            clk;
	logic            arst_n;
	inst_t     [1:0] inst;
	logic      [1:0] inst_valid;
	issue_num_t      issue_num;
	redirect_t       redirect;
	commit_t   [1:0] commit;
	int              fe_pc;          // frontend fetch index
	int              mixed_dual_cnt; // simple then mul or beq, issued as 2

	backend #(
		.MUL_CYCLES (MUL_CYCLES)
	) UUT (
		.clk          (clk),
		.arst_n_i     (arst_n),
		.inst_i       (inst),
		.inst_valid_i (inst_valid),
		.issue_num_o  (issue_num),
		.redirect_o   (redirect),
		.commit_o     (commit)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_T);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired before all instructions committed");
	end

	task automatic report_mismatch(string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "wrong value from the DUT");
	endtask

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_commit(commit_t got, commit_t exp);
		if (got.pc !== exp.pc || got.rd !== exp.rd || got.result !== exp.result) begin
			report_mismatch($sformatf(
				"commit pc %0d rd %0d result %h, expected pc %0d rd %0d result %h",
				got.pc, got.rd, got.result, exp.pc, exp.rd, exp.result));
		end
	endtask

	task automatic check_redirect(redirect_t got, redirect_t exp);
		if (got.valid !== exp.valid || got.target !== exp.target) begin
			report_mismatch($sformatf("redirect to %0d, expected %0d", got.target, exp.target));
		end
	endtask

	task automatic check_issue_num(issue_num_t got, issue_num_t limit);
		if (got > limit) begin
			report_mismatch($sformatf("issue_num %0d above limit %0d for pc %0d",
				got, limit, fe_pc));
		end
	endtask

	// most the issue rules allow for this pair
	function automatic issue_num_t pair_limit(inst_t [1:0] pair, logic [1:0] vld);
		reg_addr_t  rd0;
		reg_addr_t  rd1;
		logic       main0;
		logic       main1;
		issue_num_t lim;
		rd0   = (pair[0].op == OP_BEQ) ? reg_addr_t'(0) : pair[0].rd;
		rd1   = (pair[1].op == OP_BEQ) ? reg_addr_t'(0) : pair[1].rd;
		main0 = pair[0].op == OP_MUL || pair[0].op == OP_BEQ;
		main1 = pair[1].op == OP_MUL || pair[1].op == OP_BEQ;
		if (!vld[0]) begin
			lim = issue_num_t'(0);
		end else if (!vld[1]) begin
			lim = issue_num_t'(1);
		end else if (rd0 != '0 && (pair[1].rs1 == rd0 || pair[1].rs2 == rd0)) begin
			lim = issue_num_t'(1);
		end else if (rd0 != '0 && rd1 == rd0) begin
			lim = issue_num_t'(1);
		end else if (main0 && main1) begin
			lim = issue_num_t'(1);
		end else begin
			lim = issue_num_t'(2);
		end
		return lim;
	endfunction

	task automatic drive_frontend();
		for (int k = 0; k < 2; k++) begin
			if (fe_pc + k < PROG_LEN) begin
				inst[k]       = prog[fe_pc + k];
				inst_valid[k] = 1'b1;
			end else begin
				inst[k]       = '0;
				inst_valid[k] = 1'b0;
			end
		end
	endtask

	task automatic take_commit(commit_t c);
		if (c.valid) begin
			if (exp_commits.size() == 0) begin
				abort_run($sformatf("pc %0d committed after the program had finished",
					c.pc));
			end else begin
				check_commit(c, exp_commits.pop_front());
			end
		end
	endtask

	// outputs have settled by mid-cycle
	task automatic sample_cycle();
		issue_num_t limit;
		redirect_t  exp_redirect;
		limit = redirect.valid ? issue_num_t'(0) : pair_limit(inst, inst_valid);
		check_issue_num(issue_num, limit);
		if (issue_num == issue_num_t'(2) &&
				(inst[1].op == OP_MUL || inst[1].op == OP_BEQ)) begin
			mixed_dual_cnt++;
		end
		if (commit[1].valid && commit[1].revert) begin // older slot first
			take_commit(commit[1]);
			take_commit(commit[0]);
		end else begin
			take_commit(commit[0]);
			take_commit(commit[1]);
		end
		if (redirect.valid) begin
			if (exp_targets.size() == 0) begin
				abort_run("redirect seen although no taken branch is left");
			end else begin
				exp_redirect.valid  = 1'b1;
				exp_redirect.target = exp_targets.pop_front();
				check_redirect(redirect, exp_redirect);
				fe_pc = int'(redirect.target);
			end
		end else begin
			fe_pc += int'(issue_num);
		end
	endtask

	task automatic run_cycle();
		@(negedge clk);
		sample_cycle();
		@(posedge clk);
		#(DRIVE_DLY);
		drive_frontend();
	endtask

	initial begin
		arst_n         = 1'b0;
		inst           = '0;
		inst_valid     = '0;
		fe_pc          = 0;
		mixed_dual_cnt = 0;
		build_program();
		run_reference();
		repeat (RST_CYCLES) @(posedge clk);
		#(DRIVE_DLY);
		arst_n = 1'b1;
		drive_frontend();
		while (exp_commits.size() > 0) begin
			run_cycle();
		end
		repeat (TAIL_CYCLES) run_cycle();
		if (exp_targets.size() == 0 && mixed_dual_cnt > 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			if (exp_targets.size() != 0) begin
				$display("%0d taken branches never redirected", exp_targets.size());
			end
			if (mixed_dual_cnt == 0) begin
				$display("no simple instruction paired with mul or beq ever issued as 2");
			end
			$display("TEST FAILED");
			$fatal(1, "run ended with behaviors not seen");
		end
	end

endmodule

//--- logic/backend.sv
module backend
	import backend_pkg::*;
#(
	parameter int MUL_CYCLES = 3
) (
	input  logic           clk,
	input  logic           arst_n_i,
	input  inst_t   [1:0]  inst_i,
	input  logic    [1:0]  inst_valid_i,
	output issue_num_t     issue_num_o,
	output redirect_t      redirect_o,
	output commit_t [1:0]  commit_o
);

	logic      [1:0]  issue_vec;
	logic             revert;
	logic      [1:0]  pipe_issue;
	inst_t     [1:0]  pipe_inst;
	lvl_vec_t  [1:0]  stall_req;
	lvl_vec_t  [1:0]  stall_vec;
	lvl_vec_t  [1:0]  clr_vec;
	lvl_vec_t         clr_req;
	logic             ex_revert;
	fwd_src_t  [1:0]  m1_src;
	fwd_src_t  [1:0]  m2_src;
	fwd_src_t  [3:0]  fwd_src;
	reg_addr_t [3:0]  r_addr;   // pipe 0 on [1:0]
	data_t     [3:0]  r_data;
	logic      [1:0]  w_en;
	reg_addr_t [1:0]  w_addr;
	data_t     [1:0]  w_data;

	issue issue_module (
		.inst_i         (inst_i),
		.inst_valid_i   (inst_valid_i),
		.ex_stall_i     (stall_vec[0][0]),
		.clr_frontend_i (redirect_o.valid), // taken branch blocks issue
		.issue_o        (issue_vec),
		.revert_o       (revert),
		.issue_num_o    (issue_num_o)
	);

	// steering, swapped pair sends inst 0 to pipe 1
	assign pipe_issue[0] = revert ? issue_vec[1] : issue_vec[0];
	assign pipe_issue[1] = revert ? issue_vec[0] : issue_vec[1];
	assign pipe_inst[0]  = inst_i[revert];
	assign pipe_inst[1]  = inst_i[!revert];

	assign fwd_src = {m2_src[1], m2_src[0], m1_src[1], m1_src[0]};

	// write ports from m2
	assign w_en[0]   = commit_o[0].valid;
	assign w_en[1]   = commit_o[1].valid;
	assign w_addr[0] = commit_o[0].rd;
	assign w_addr[1] = commit_o[1].rd;
	assign w_data[0] = commit_o[0].result;
	assign w_data[1] = commit_o[1].result;

	reg_file reg_file_module (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.w_en_i   (w_en),
		.w_addr_i (w_addr),
		.w_data_i (w_data),
		.r_addr_i (r_addr),
		.r_data_o (r_data)
	);

	backend_pipeline #(
		.MAIN_PIPE  (1'b1),
		.MUL_CYCLES (MUL_CYCLES)
	) pipeline_0 (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.issue_i     (pipe_issue[0]),
		.inst_i      (pipe_inst[0]),
		.revert_i    (revert),
		.stall_i     (stall_vec[0]),
		.clr_i       (clr_vec[0]),
		.fwd_src_i   (fwd_src),
		.m1_src_o    (m1_src[0]),
		.m2_src_o    (m2_src[0]),
		.r_addr_o    (r_addr[1:0]),
		.r_data_i    (r_data[1:0]),
		.stall_req_o (stall_req[0]),
		.clr_req_o   (clr_req),
		.ex_revert_o (ex_revert),
		.redirect_o  (redirect_o),
		.commit_o    (commit_o[0])
	);

	backend_pipeline #(
		.MAIN_PIPE  (1'b0),
		.MUL_CYCLES (MUL_CYCLES)
	) pipeline_1 (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.issue_i     (pipe_issue[1]),
		.inst_i      (pipe_inst[1]),
		.revert_i    (revert),
		.stall_i     (stall_vec[1]),
		.clr_i       (clr_vec[1]),
		.fwd_src_i   (fwd_src),
		.m1_src_o    (m1_src[1]),
		.m2_src_o    (m2_src[1]),
		.r_addr_o    (r_addr[3:2]),
		.r_data_i    (r_data[3:2]),
		.stall_req_o (stall_req[1]),
		.clr_req_o   (),
		.ex_revert_o (),
		.redirect_o  (),
		.commit_o    (commit_o[1])
	);

	stall_clear_ctrl stall_clear_module (
		.stall_req_i (stall_req),
		.clr_req_i   (clr_req),
		.ex_revert_i (ex_revert),
		.stall_o     (stall_vec),
		.clr_o       (clr_vec)
	);

endmodule

//--- logic/stall_clear_ctrl.sv
module stall_clear_ctrl
	import backend_pkg::*;
(
	input  lvl_vec_t [1:0] stall_req_i,  // per pipe
	input  lvl_vec_t       clr_req_i,    // pipe 0 only
	input  logic           ex_revert_i,
	output lvl_vec_t [1:0] stall_o,
	output lvl_vec_t [1:0] clr_o
);

	logic m1_stall;
	logic ex_stall;
	logic kill_p1_ex;

	// a stall at one level holds that level and everything before it
	assign m1_stall = stall_req_i[0][1] | stall_req_i[1][1];
	assign ex_stall = m1_stall | stall_req_i[0][0] | stall_req_i[1][0];

	always_comb begin
		for (int p = 0; p < 2; p++) begin
			stall_o[p] = {m1_stall, ex_stall}; // both pipes move in lockstep
		end
	end

	// ex partner dies only when it is the younger one
	assign kill_p1_ex = clr_req_i[0] & ~ex_revert_i;

	assign clr_o[0] = '0; // the branch itself commits
	assign clr_o[1] = {1'b0, kill_p1_ex};

endmodule

//--- logic/backend_pipeline.sv
module backend_pipeline
	import backend_pkg::*;
#(
	parameter bit MAIN_PIPE  = 1'b0,
	parameter int MUL_CYCLES = 3
) (
	input  logic                clk,
	input  logic                arst_n_i,
	input  logic                issue_i,
	input  inst_t               inst_i,
	input  logic                revert_i,
	input  lvl_vec_t            stall_i,
	input  lvl_vec_t            clr_i,
	input  fwd_src_t  [3:0]     fwd_src_i,  // m1 p0, m1 p1, m2 p0, m2 p1
	output fwd_src_t            m1_src_o,
	output fwd_src_t            m2_src_o,
	output reg_addr_t [1:0]     r_addr_o,
	input  data_t     [1:0]     r_data_i,
	output lvl_vec_t            stall_req_o,
	output lvl_vec_t            clr_req_o,
	output logic                ex_revert_o, // ex pair swapped
	output redirect_t           redirect_o,
	output commit_t             commit_o
);

	typedef struct packed {
		inst_t inst;
		logic  older;
	} ex_reg_t;

	typedef struct packed {
		pc_t       pc;
		op_t       op;
		reg_addr_t rd;
		data_t     a;
		data_t     b;
		data_t     result;
		logic      older;
	} m1_reg_t;

	typedef struct packed {
		pc_t       pc;
		reg_addr_t rd;
		data_t     result;
		logic      older;
	} m2_reg_t;

	logic            ex_valid_q;
	logic            m1_valid_q;
	logic            m2_valid_q;
	ex_reg_t         ex_q;
	m1_reg_t         m1_q;
	m2_reg_t         m2_q;
	logic            older_in;
	fwd_src_t [1:0]  opnd;       // operand value plus busy flag
	data_t           ex_result;
	data_t           m1_result;
	logic            ex_stall_req;
	logic            m1_stall_req;
	logic            br_taken;

	// the youngest match in program order wins
	// priority rises from m2 older to m1 younger
	function automatic fwd_src_t fwd_pick(reg_addr_t addr, data_t rf_data,
			fwd_src_t [3:0] srcs);
		fwd_src_t pick;
		fwd_src_t s;
		pick = '0;
		pick.result = rf_data;
		for (int lvl = 1; lvl >= 0; lvl--) begin
			for (int young = 0; young < 2; young++) begin
				for (int p = 0; p < 2; p++) begin
					s = srcs[2 * lvl + p];
					if (s.valid && s.rd != '0 && s.rd == addr && s.revert != young[0]) begin
						pick = s;
					end
				end
			end
		end
		return pick;
	endfunction

	assign older_in    = MAIN_PIPE ? !revert_i : revert_i;
	assign ex_revert_o = MAIN_PIPE ? !ex_q.older : ex_q.older;

	assign r_addr_o[0] = ex_q.inst.rs1;
	assign r_addr_o[1] = ex_q.inst.rs2;

	assign opnd[0] = fwd_pick(ex_q.inst.rs1, r_data_i[0], fwd_src_i);
	assign opnd[1] = fwd_pick(ex_q.inst.rs2, r_data_i[1], fwd_src_i);

	assign ex_stall_req = ex_valid_q && (opnd[0].busy || opnd[1].busy); // wait on multiply

	always_comb begin
		case (ex_q.inst.op)
			OP_ADD:  ex_result = opnd[0].result + opnd[1].result;
			OP_SUB:  ex_result = opnd[0].result - opnd[1].result;
			OP_AND:  ex_result = opnd[0].result & opnd[1].result;
			OP_OR:   ex_result = opnd[0].result | opnd[1].result;
			OP_XOR:  ex_result = opnd[0].result ^ opnd[1].result;
			OP_SLT:  ex_result = data_t'($signed(opnd[0].result) < $signed(opnd[1].result));
			default: ex_result = '0; // mul finishes in m1
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_valid_q <= 1'b0;
			m1_valid_q <= 1'b0;
			m2_valid_q <= 1'b0;
		end else begin
			if (!stall_i[0]) begin
				ex_valid_q <= issue_i;
			end else if (clr_i[0]) begin
				ex_valid_q <= 1'b0;
			end
			if (!stall_i[1]) begin
				m1_valid_q <= ex_valid_q && !stall_i[0] && !clr_i[0]; // bubble behind a stall
			end else if (clr_i[1]) begin
				m1_valid_q <= 1'b0;
			end
			m2_valid_q <= m1_valid_q && !stall_i[1] && !clr_i[1];
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i[0]) begin
			ex_q <= '{inst: inst_i, older: older_in};
		end
		if (!stall_i[1]) begin
			m1_q <= '{pc: ex_q.inst.pc, op: ex_q.inst.op, rd: wb_rd(ex_q.inst),
				a: opnd[0].result, b: opnd[1].result, result: ex_result, older: ex_q.older};
		end
		m2_q <= '{pc: m1_q.pc, rd: m1_q.rd, result: m1_result, older: m1_q.older};
	end

	if (MAIN_PIPE) begin : g_main
		localparam int CNT_W = $clog2(MUL_CYCLES + 1);

		typedef enum logic {mul_idle, mul_busy} mul_state_e;

		mul_state_e       state_q, state_d;
		logic [CNT_W-1:0] cnt_q; // cycles spent in m1
		logic             m1_is_mul;

		assign m1_is_mul = m1_valid_q && m1_q.op == OP_MUL;
		assign m1_result = (m1_q.op == OP_MUL) ? m1_q.a * m1_q.b : m1_q.result;

		// branch resolves only once its operands are final
		assign br_taken = ex_valid_q && ex_q.inst.op == OP_BEQ &&
			opnd[0].result == opnd[1].result && !stall_i[0];

		always_comb begin
			state_d = state_q;
			m1_stall_req = 1'b0;
			case (state_q)
				mul_idle: begin
					if (m1_is_mul && MUL_CYCLES > 1) begin
						state_d = mul_busy;
						m1_stall_req = 1'b1;
					end
				end
				mul_busy: begin
					if (!m1_is_mul || cnt_q == CNT_W'(MUL_CYCLES - 1)) begin
						state_d = mul_idle; // product leaves m1 on the last cycle
					end else begin
						m1_stall_req = 1'b1;
					end
				end
				default: state_d = mul_idle;
			endcase
		end

		always_ff @(posedge clk or negedge arst_n_i) begin
			if (!arst_n_i) begin
				state_q <= mul_idle;
				cnt_q <= '0;
			end else begin
				state_q <= state_d;
				cnt_q <= (state_q == mul_idle) ? CNT_W'(1) : cnt_q + 1'b1;
			end
		end
	end else begin : g_simple
		assign m1_result    = m1_q.result;
		assign m1_stall_req = 1'b0;
		assign br_taken     = 1'b0;
	end

	assign stall_req_o = {m1_stall_req, ex_stall_req};
	assign clr_req_o   = {1'b0, br_taken};
	assign redirect_o  = '{valid: br_taken, target: ex_q.inst.target};

	assign m1_src_o = '{valid: m1_valid_q, rd: m1_q.rd, result: m1_result,
		revert: m1_q.older, busy: m1_stall_req};
	assign m2_src_o = '{valid: m2_valid_q, rd: m2_q.rd, result: m2_q.result,
		revert: m2_q.older, busy: 1'b0};
	assign commit_o = '{valid: m2_valid_q, pc: m2_q.pc, rd: m2_q.rd,
		result: m2_q.result, revert: m2_q.older};

endmodule

//--- logic/reg_file.sv
module reg_file
	import backend_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic      [1:0]       w_en_i,
	input  reg_addr_t [1:0]       w_addr_i,
	input  data_t     [1:0]       w_data_i,
	input  reg_addr_t [3:0]       r_addr_i,
	output data_t     [3:0]       r_data_o
);

	data_t [31:0] regs_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			regs_q <= '0;
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (w_en_i[w] && w_addr_i[w] != '0) begin // x0 never written
					regs_q[w_addr_i[w]] <= w_data_i[w];
				end
			end
		end
	end

	// reads see same-cycle writes
	always_comb begin
		for (int r = 0; r < 4; r++) begin
			r_data_o[r] = regs_q[r_addr_i[r]];
			for (int w = 0; w < 2; w++) begin
				if (w_en_i[w] && w_addr_i[w] == r_addr_i[r]) begin
					r_data_o[r] = w_data_i[w];
				end
			end
			if (r_addr_i[r] == '0) begin
				r_data_o[r] = '0;
			end
		end
	end

endmodule

//--- logic/issue.sv
module issue
	import backend_pkg::*;
(
	input  inst_t [1:0] inst_i,
	input  logic  [1:0] inst_valid_i,
	input  logic        ex_stall_i,
	input  logic        clr_frontend_i,
	output logic  [1:0] issue_o,
	output logic        revert_o,
	output issue_num_t  issue_num_o
);

	logic [1:0] main_only; // needs pipe 0
	reg_addr_t  rd0;
	reg_addr_t  rd1;
	logic       raw_hazard;
	logic       waw_hazard;
	logic       both_main;
	logic       can_issue;

	always_comb begin
		for (int k = 0; k < 2; k++) begin
			main_only[k] = inst_i[k].op inside {OP_MUL, OP_BEQ};
		end
	end

	assign rd0 = wb_rd(inst_i[0]);
	assign rd1 = wb_rd(inst_i[1]);

	// inst 1 reads what inst 0 produces
	assign raw_hazard = (rd0 != '0) &&
		((inst_i[1].rs1 == rd0) || (inst_i[1].rs2 == rd0));

	// same destination would collide on the write ports
	assign waw_hazard = (rd0 != '0) && (rd1 == rd0);

	assign both_main = main_only[0] && main_only[1];

	assign can_issue = !ex_stall_i && !clr_frontend_i;

	assign issue_o[0] = can_issue && inst_valid_i[0];
	assign issue_o[1] = issue_o[0] && inst_valid_i[1] &&
		!raw_hazard && !waw_hazard && !both_main;

	// main-pipe-only inst 1 swaps the pair, inst 0 then runs in pipe 1
	assign revert_o = inst_valid_i[1] && main_only[1] && !main_only[0];

	assign issue_num_o = {issue_o[1], issue_o[0] & ~issue_o[1]};

endmodule

//--- logic/backend_pkg.sv
package backend_pkg;

	localparam int DATA_W = 32;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [4:0]        reg_addr_t;
	typedef logic [7:0]        pc_t;        // instruction index
	typedef logic [2:0]        op_t;
	typedef logic [1:0]        lvl_vec_t;   // bit 0 ex, bit 1 m1
	typedef logic [1:0]        issue_num_t; // 0, 1 or 2

	localparam op_t OP_ADD = 3'd0;
	localparam op_t OP_SUB = 3'd1;
	localparam op_t OP_AND = 3'd2;
	localparam op_t OP_OR  = 3'd3;
	localparam op_t OP_XOR = 3'd4;
	localparam op_t OP_SLT = 3'd5; // signed compare
	localparam op_t OP_MUL = 3'd6; // pipe 0 only
	localparam op_t OP_BEQ = 3'd7; // pipe 0 only

	typedef struct packed {
		pc_t       pc;
		op_t       op;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		pc_t       target; // absolute, beq only
	} inst_t;

	// one stage register as seen by the forwarding logic
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		data_t     result;
		logic      revert; // this pipe holds the older one of the pair
		logic      busy;   // multiply still running
	} fwd_src_t;

	typedef struct packed {
		logic      valid;
		pc_t       pc;
		reg_addr_t rd;
		data_t     result;
		logic      revert; // this pipe holds the older one of the pair
	} commit_t;

	typedef struct packed {
		logic valid;
		pc_t  target;
	} redirect_t;

	// beq writes no register
	function automatic reg_addr_t wb_rd(inst_t inst);
		return (inst.op == OP_BEQ) ? reg_addr_t'(0) : inst.rd;
	endfunction

endpackage
